// File: Bender.yml
package:
  name: lagd_digital_macro

sources:
  - include_dirs:
      - hw
    files:
      - hw/lagd_pkg.sv
      - hw/weight_dispatch.sv
      - hw/local_energy_unit.sv
      - hw/energy_accumulator.sv
      - hw/flip_manager.sv
      - hw/digital_macro.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/tb_digital_macro.sv

// File: hw/digital_macro.sv
`timescale 1ns/1ps
`include "lagd_defs.svh"

module digital_macro import lagd_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    // config
    input  logic config_valid_i,
    input  spin_t config_spin_initial_i,
    output logic config_ready_o,
    // run control
    input  logic cmpt_en_i,
    input  logic en_comparison_i,
    output logic cmpt_idle_o,
    // icon memory
    output logic flip_ren_o,
    output icon_addr_t flip_raddr_o,
    input  icon_addr_t icon_last_raddr_plus_one_i,
    input  spin_t flip_rdata_i,
    // weight source
    input  logic weight_valid_i,
    output logic weight_ready_o,
    input  logic [`PARALLELISM*`NUM_SPIN*`BIT_J-1:0] weight_i,
    input  logic [`PARALLELISM*`BIT_H-1:0] hbias_i,
    // results
    output spin_t spin_o,
    output energy_t energy_o
);
    localparam int ROW_BIT = `NUM_SPIN * `BIT_J;

    logic cand_valid;
    logic cand_ready;
    spin_t cand_spin;
    logic acc_busy;
    logic lane_valid;
    spin_t lane_spin;
    logic [`PARALLELISM*ROW_BIT-1:0] lane_j;
    logic [`PARALLELISM*`BIT_H-1:0] lane_h;
    logic [`PARALLELISM-1:0] lane_row_spin;
    logic [`PARALLELISM-1:0] lane_res_valid;
    local_energy_t [`PARALLELISM-1:0] lane_energy;
    logic energy_valid;
    logic energy_ready;
    energy_t energy;

    weight_dispatch u_dispatch (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .cand_valid_i    (cand_valid),
        .cand_spin_i     (cand_spin),
        .cand_ready_o    (cand_ready),
        .weight_valid_i  (weight_valid_i),
        .weight_i        (weight_i),
        .hbias_i         (hbias_i),
        .weight_ready_o  (weight_ready_o),
        .acc_busy_i      (acc_busy),
        .lane_valid_o    (lane_valid),
        .lane_spin_o     (lane_spin),
        .lane_j_o        (lane_j),
        .lane_h_o        (lane_h),
        .lane_row_spin_o (lane_row_spin)
    );

    for (genvar l = 0; l < `PARALLELISM; l++) begin : gen_lane
        local_energy_unit u_lane (
            .clk_i          (clk_i),
            .rst_i          (rst_i),
            .valid_i        (lane_valid),
            .spin_i         (lane_spin),
            .j_row_i        (lane_j[l*ROW_BIT +: ROW_BIT]),
            .h_i            (lane_h[l*`BIT_H +: `BIT_H]),
            .row_spin_i     (lane_row_spin[l]),
            .valid_o        (lane_res_valid[l]),
            .local_energy_o (lane_energy[l])
        );
    end

    // lanes run in lockstep
    energy_accumulator u_accumulator (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .res_valid_i    (&lane_res_valid),
        .local_energy_i (lane_energy),
        .energy_valid_o (energy_valid),
        .energy_o       (energy),
        .energy_ready_i (energy_ready),
        .busy_o         (acc_busy)
    );

    flip_manager u_flip_manager (
        .clk_i                      (clk_i),
        .rst_i                      (rst_i),
        .config_valid_i             (config_valid_i),
        .config_spin_initial_i      (config_spin_initial_i),
        .config_ready_o             (config_ready_o),
        .cmpt_en_i                  (cmpt_en_i),
        .en_comparison_i            (en_comparison_i),
        .cmpt_idle_o                (cmpt_idle_o),
        .flip_ren_o                 (flip_ren_o),
        .flip_raddr_o               (flip_raddr_o),
        .icon_last_raddr_plus_one_i (icon_last_raddr_plus_one_i),
        .flip_rdata_i               (flip_rdata_i),
        .cand_valid_o               (cand_valid),
        .cand_spin_o                (cand_spin),
        .cand_ready_i               (cand_ready),
        .energy_valid_i             (energy_valid),
        .energy_i                   (energy),
        .energy_ready_o             (energy_ready),
        .spin_o                     (spin_o),
        .energy_o                   (energy_o)
    );

endmodule

// File: hw/energy_accumulator.sv
`timescale 1ns/1ps
`include "lagd_defs.svh"

module energy_accumulator import lagd_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    input  logic res_valid_i,
    input  local_energy_t [`PARALLELISM-1:0] local_energy_i,
    output logic energy_valid_o,
    output energy_t energy_o,
    input  logic energy_ready_i,
    output logic busy_o
);
    localparam int CNT_BIT = (`NUM_BEATS > 1) ? $clog2(`NUM_BEATS) : 1;

    logic [CNT_BIT-1:0] cnt_q;
    energy_t total_q;
    energy_t beat_sum;
    energy_t lane_ext;

    // sign-extend each lane before adding
    always_comb begin
        beat_sum = '0;
        lane_ext = '0;
        for (int l = 0; l < `PARALLELISM; l++) begin
            lane_ext = local_energy_i[l];
            beat_sum = beat_sum + lane_ext;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
            total_q <= '0;
            energy_valid_o <= 1'b0;
        end else if (energy_valid_o && energy_ready_i) begin
            // result taken, start clean for next candidate
            cnt_q <= '0;
            total_q <= '0;
            energy_valid_o <= 1'b0;
        end else if (res_valid_i && !energy_valid_o) begin
            total_q <= total_q + beat_sum;
            if (cnt_q == CNT_BIT'(`NUM_BEATS - 1)) begin
                cnt_q <= '0;
                energy_valid_o <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign energy_o = total_q;
    assign busy_o = energy_valid_o;

    assert property (@(posedge clk_i) disable iff (rst_i)
        (energy_valid_o && !energy_ready_i) |=> (energy_valid_o && $stable(energy_o)));

endmodule

// File: hw/flip_manager.sv
`timescale 1ns/1ps
`include "lagd_defs.svh"

module flip_manager import lagd_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    // config
    input  logic config_valid_i,
    input  spin_t config_spin_initial_i,
    output logic config_ready_o,
    // run control
    input  logic cmpt_en_i,
    input  logic en_comparison_i,
    output logic cmpt_idle_o,
    // icon memory
    output logic flip_ren_o,
    output icon_addr_t flip_raddr_o,
    input  icon_addr_t icon_last_raddr_plus_one_i,
    input  spin_t flip_rdata_i,
    // candidate to dispatcher
    output logic cand_valid_o,
    output spin_t cand_spin_o,
    input  logic cand_ready_i,
    // energy from accumulator
    input  logic energy_valid_i,
    input  energy_t energy_i,
    output logic energy_ready_o,
    // results
    output spin_t spin_o,
    output energy_t energy_o
);
    fm_state_e state_q;
    icon_addr_t raddr_q;
    logic first_q;
    logic rd_pend_q;
    logic accept;
    spin_t spin_q;
    spin_t cand_q;
    energy_t best_q;

    assign config_ready_o = (state_q == FM_IDLE);
    assign cmpt_idle_o = (state_q == FM_IDLE);
    assign flip_ren_o = (state_q == FM_READ) && !rd_pend_q;
    assign flip_raddr_o = raddr_q;
    assign cand_valid_o = (state_q == FM_EVAL);
    assign cand_spin_o = cand_q;
    assign energy_ready_o = (state_q == FM_WAIT);
    assign spin_o = spin_q;
    assign energy_o = best_q;

    // first evaluation seeds the best energy
    assign accept = first_q || !en_comparison_i || (energy_i < best_q);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= FM_IDLE;
            raddr_q <= '0;
            first_q <= 1'b0;
            rd_pend_q <= 1'b0;
        end else begin
            case (state_q)
                FM_IDLE: begin
                    if (cmpt_en_i) begin
                        state_q <= FM_EVAL;
                        raddr_q <= '0;
                        first_q <= 1'b1;
                    end
                end
                FM_READ: begin
                    // icon data arrives one cycle after the read strobe
                    if (!rd_pend_q) begin
                        rd_pend_q <= 1'b1;
                        raddr_q <= raddr_q + 1'b1;
                    end else begin
                        rd_pend_q <= 1'b0;
                        state_q <= FM_EVAL;
                    end
                end
                FM_EVAL: begin
                    if (cand_ready_i) begin
                        state_q <= FM_WAIT;
                    end
                end
                FM_WAIT: begin
                    if (energy_valid_i) begin
                        first_q <= 1'b0;
                        if (raddr_q < icon_last_raddr_plus_one_i) begin
                            state_q <= FM_READ;
                        end else begin
                            state_q <= FM_IDLE;
                        end
                    end
                end
                default: state_q <= FM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (config_valid_i && config_ready_o) begin
            spin_q <= config_spin_initial_i;
        end else if (state_q == FM_WAIT && energy_valid_i && accept) begin
            spin_q <= cand_q;
        end
        if (state_q == FM_WAIT && energy_valid_i && accept) begin
            best_q <= energy_i;
        end
        if (state_q == FM_IDLE && cmpt_en_i) begin
            cand_q <= spin_q;
        end else if (state_q == FM_READ && rd_pend_q) begin
            cand_q <= spin_q ^ flip_rdata_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        flip_ren_o |-> (flip_raddr_o < icon_last_raddr_plus_one_i));

endmodule

// File: hw/lagd_defs.svh
`ifndef LAGD_DEFS_SVH
`define LAGD_DEFS_SVH

// problem size
`define NUM_SPIN 16
`define BIT_J 4
`define BIT_H 4

// lanes, one row each per weight beat
`define PARALLELISM 4
`define NUM_BEATS (`NUM_SPIN / `PARALLELISM)

// energy widths
`define LOCAL_ENERGY_BIT 12
`define ENERGY_TOTAL_BIT 16

// flip-icon memory
`define ICON_ADDR_BIT 4

`endif

// File: hw/lagd_pkg.sv
`include "lagd_defs.svh"

package lagd_pkg;

    // bit 1 is spin +1, bit 0 is spin -1
    typedef logic [`NUM_SPIN-1:0] spin_t;

    typedef logic signed [`LOCAL_ENERGY_BIT-1:0] local_energy_t;
    typedef logic signed [`ENERGY_TOTAL_BIT-1:0] energy_t;

    // one extra bit so the last-plus-one bound fits
    typedef logic [`ICON_ADDR_BIT:0] icon_addr_t;

    typedef enum logic {
        DISP_IDLE,
        DISP_LOAD
    } disp_state_e;

    typedef enum logic [1:0] {
        FM_IDLE,
        FM_READ,
        FM_EVAL,
        FM_WAIT
    } fm_state_e;

endpackage

// File: hw/local_energy_unit.sv
`timescale 1ns/1ps
`include "lagd_defs.svh"

module local_energy_unit import lagd_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    input  logic valid_i,
    input  spin_t spin_i,
    input  logic [`NUM_SPIN*`BIT_J-1:0] j_row_i,
    input  logic signed [`BIT_H-1:0] h_i,
    input  logic row_spin_i,
    output logic valid_o,
    output local_energy_t local_energy_o
);
    local_energy_t row_sum;
    local_energy_t j_ext;
    local_energy_t local_energy_d;

    // h + sum of J_rj * s_j, with s_j = +1 or -1
    always_comb begin
        row_sum = h_i;
        j_ext = '0;
        for (int j = 0; j < `NUM_SPIN; j++) begin
            j_ext = signed'(j_row_i[j*`BIT_J +: `BIT_J]);
            if (spin_i[j]) begin
                row_sum = row_sum + j_ext;
            end else begin
                row_sum = row_sum - j_ext;
            end
        end
        // times s_r
        local_energy_d = row_spin_i ? row_sum : -row_sum;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            local_energy_o <= local_energy_d;
        end
    end

endmodule

// File: hw/weight_dispatch.sv
`timescale 1ns/1ps
`include "lagd_defs.svh"

module weight_dispatch import lagd_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    // candidate from flip manager
    input  logic cand_valid_i,
    input  spin_t cand_spin_i,
    output logic cand_ready_o,
    // weight source
    input  logic weight_valid_i,
    input  logic [`PARALLELISM*`NUM_SPIN*`BIT_J-1:0] weight_i,
    input  logic [`PARALLELISM*`BIT_H-1:0] hbias_i,
    output logic weight_ready_o,
    input  logic acc_busy_i,
    // lanes
    output logic lane_valid_o,
    output spin_t lane_spin_o,
    output logic [`PARALLELISM*`NUM_SPIN*`BIT_J-1:0] lane_j_o,
    output logic [`PARALLELISM*`BIT_H-1:0] lane_h_o,
    output logic [`PARALLELISM-1:0] lane_row_spin_o
);
    localparam int BEAT_BIT = (`NUM_BEATS > 1) ? $clog2(`NUM_BEATS) : 1;

    disp_state_e state_q;
    logic [BEAT_BIT-1:0] beat_q;
    logic beat_last;
    logic beat_fire;
    spin_t spin_q;

    assign cand_ready_o = (state_q == DISP_IDLE);
    // stall while the accumulator still holds an untaken total
    assign weight_ready_o = (state_q == DISP_LOAD) && !acc_busy_i;
    assign beat_fire = weight_valid_i && weight_ready_o;
    assign beat_last = (beat_q == BEAT_BIT'(`NUM_BEATS - 1));
    assign lane_spin_o = spin_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= DISP_IDLE;
            beat_q <= '0;
            lane_valid_o <= 1'b0;
        end else begin
            lane_valid_o <= beat_fire;
            case (state_q)
                DISP_IDLE: begin
                    if (cand_valid_i) begin
                        state_q <= DISP_LOAD;
                        beat_q <= '0;
                    end
                end
                DISP_LOAD: begin
                    if (beat_fire) begin
                        beat_q <= beat_last ? '0 : beat_q + 1'b1;
                        if (beat_last) begin
                            state_q <= DISP_IDLE;
                        end
                    end
                end
                default: state_q <= DISP_IDLE;
            endcase
        end
    end

    // lane l takes row beat*PARALLELISM+l from slice l of the beat
    always_ff @(posedge clk_i) begin
        if (cand_valid_i && cand_ready_o) begin
            spin_q <= cand_spin_i;
        end
        if (beat_fire) begin
            lane_j_o <= weight_i;
            lane_h_o <= hbias_i;
            for (int l = 0; l < `PARALLELISM; l++) begin
                lane_row_spin_o[l] <= spin_q[beat_q * `PARALLELISM + l];
            end
        end
    end

    // no beat left over in idle, the next candidate starts at beat 0
    assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == DISP_IDLE) |-> (beat_q == '0));

endmodule

// File: tb.f
+incdir+hw
hw/lagd_pkg.sv
hw/weight_dispatch.sv
hw/local_energy_unit.sv
hw/energy_accumulator.sv
hw/flip_manager.sv
hw/digital_macro.sv
verification/tb_digital_macro.sv

// File: verification/tb_digital_macro.sv
`timescale 1ns/1ps
`include "lagd_defs.svh"

module tb_digital_macro import lagd_pkg::*; ();
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 8;
    localparam int MULTI_ROUNDS = 6;
    localparam int TOTAL_RUNS = 4 + MULTI_ROUNDS;
    localparam int MAX_ICONS = 1 << `ICON_ADDR_BIT;
    localparam int WATCHDOG_CYCLES = TOTAL_RUNS * (MAX_ICONS + 1) * `NUM_BEATS * 8 + 400;

    logic clk_i;
    logic rst_i;
    logic config_valid_i;
    spin_t config_spin_initial_i;
    logic config_ready_o;
    logic cmpt_en_i;
    logic en_comparison_i;
    logic cmpt_idle_o;
    logic flip_ren_o;
    icon_addr_t flip_raddr_o;
    icon_addr_t icon_last_raddr_plus_one_i;
    spin_t flip_rdata_i;
    logic weight_valid_i;
    logic weight_ready_o;
    logic [`PARALLELISM*`NUM_SPIN*`BIT_J-1:0] weight_i;
    logic [`PARALLELISM*`BIT_H-1:0] hbias_i;
    spin_t spin_o;
    energy_t energy_o;

    // problem instance and icon memory
    logic signed [`BIT_J-1:0] j_mat [`NUM_SPIN][`NUM_SPIN];
    logic signed [`BIT_H-1:0] h_vec [`NUM_SPIN];
    spin_t icons [MAX_ICONS];

    integer seed = 32'haed8897a;
    integer gap_seed;
    int error_count = 0;
    int check_count = 0;
    bit stall_en = 1'b0;
    int beat_idx = 0;
    bit pending_fire = 1'b0;
    bit rd_req = 1'b0;
    icon_addr_t rd_addr = '0;

    digital_macro i_dut (
        .clk_i                      (clk_i),
        .rst_i                      (rst_i),
        .config_valid_i             (config_valid_i),
        .config_spin_initial_i      (config_spin_initial_i),
        .config_ready_o             (config_ready_o),
        .cmpt_en_i                  (cmpt_en_i),
        .en_comparison_i            (en_comparison_i),
        .cmpt_idle_o                (cmpt_idle_o),
        .flip_ren_o                 (flip_ren_o),
        .flip_raddr_o               (flip_raddr_o),
        .icon_last_raddr_plus_one_i (icon_last_raddr_plus_one_i),
        .flip_rdata_i               (flip_rdata_i),
        .weight_valid_i             (weight_valid_i),
        .weight_ready_o             (weight_ready_o),
        .weight_i                   (weight_i),
        .hbias_i                    (hbias_i),
        .spin_o                     (spin_o),
        .energy_o                   (energy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // weight source restarts at beat 0 after every NUM_BEATS transfers
    always @(negedge clk_i) begin
        if (pending_fire) begin
            beat_idx = (beat_idx + 1) % `NUM_BEATS;
        end
        if (pending_fire || !weight_valid_i) begin
            if (stall_en) begin
                weight_valid_i = ($random(gap_seed) & 1) != 0;
            end else begin
                weight_valid_i = 1'b1;
            end
        end
        for (int l = 0; l < `PARALLELISM; l++) begin
            hbias_i[l*`BIT_H +: `BIT_H] = h_vec[beat_idx*`PARALLELISM + l];
            for (int j = 0; j < `NUM_SPIN; j++) begin
                weight_i[(l*`NUM_SPIN + j)*`BIT_J +: `BIT_J] =
                    j_mat[beat_idx*`PARALLELISM + l][j];
            end
        end
        // ready moves only on rising edges so this predicts the next edge
        pending_fire = weight_valid_i && weight_ready_o;
    end

    // icon memory with one cycle read latency
    always @(negedge clk_i) begin
        if (rd_req) begin
            flip_rdata_i = icons[rd_addr[`ICON_ADDR_BIT-1:0]];
        end
        rd_req = flip_ren_o;
        rd_addr = flip_raddr_o;
    end

    function automatic energy_t model_energy(input spin_t s);
        int total;
        int row;
        int sj;
        total = 0;
        for (int r = 0; r < `NUM_SPIN; r++) begin
            row = h_vec[r];
            for (int j = 0; j < `NUM_SPIN; j++) begin
                sj = s[j] ? 1 : -1;
                row = row + j_mat[r][j] * sj;
            end
            total = s[r] ? total + row : total - row;
        end
        return energy_t'(total);
    endfunction

    // greedy walk over the icons
    task automatic model_run(input spin_t init, input int n, input logic cmp,
                             output spin_t res_spin, output energy_t res_energy);
        spin_t cand;
        energy_t e;
        res_spin = init;
        res_energy = model_energy(init);
        for (int i = 0; i < n; i++) begin
            cand = res_spin ^ icons[i];
            e = model_energy(cand);
            if (!cmp || e < res_energy) begin
                res_spin = cand;
                res_energy = e;
            end
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_spin(input string name, input spin_t exp, input spin_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_energy(input string name, input energy_t exp, input energy_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic set_stall(input bit en);
        @(posedge clk_i);
        stall_en = en;
    endtask

    task automatic fill_icons();
        for (int i = 0; i < MAX_ICONS; i++) begin
            icons[i] = spin_t'($random(seed));
        end
    endtask

    task automatic run_round(input spin_t init, input icon_addr_t n, input logic cmp,
                             output spin_t res_spin, output energy_t res_energy);
        @(negedge clk_i);
        config_valid_i = 1'b1;
        config_spin_initial_i = init;
        icon_last_raddr_plus_one_i = n;
        en_comparison_i = cmp;
        while (!config_ready_o) @(negedge clk_i);
        @(negedge clk_i);
        config_valid_i = 1'b0;
        cmpt_en_i = 1'b1;
        @(negedge clk_i);
        cmpt_en_i = 1'b0;
        while (!cmpt_idle_o) @(negedge clk_i);
        res_spin = spin_o;
        res_energy = energy_o;
    endtask

    task automatic check_round(input string name, input spin_t init, input icon_addr_t n,
                               input logic cmp, input spin_t act_spin,
                               input energy_t act_energy);
        spin_t exp_spin;
        energy_t exp_energy;
        model_run(init, n, cmp, exp_spin, exp_energy);
        check_spin({name, " spin"}, exp_spin, act_spin);
        check_energy({name, " energy"}, exp_energy, act_energy);
    endtask

    initial begin
        spin_t init;
        spin_t exp_spin;
        spin_t act_spin;
        spin_t base_spin;
        energy_t act_energy;
        energy_t base_energy;
        icon_addr_t n;
        logic cmp;

        rst_i = 1'b1;
        config_valid_i = 1'b0;
        config_spin_initial_i = '0;
        cmpt_en_i = 1'b0;
        en_comparison_i = 1'b0;
        icon_last_raddr_plus_one_i = '0;
        flip_rdata_i = '0;
        weight_valid_i = 1'b0;
        weight_i = '0;
        hbias_i = '0;
        gap_seed = $random(seed);
        for (int r = 0; r < `NUM_SPIN; r++) begin
            h_vec[r] = $random(seed);
            for (int j = 0; j < `NUM_SPIN; j++) begin
                j_mat[r][j] = $random(seed);
            end
        end
        fill_icons();

        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;
        check_bit("reset cmpt_idle_o", 1'b1, cmpt_idle_o);
        check_bit("reset config_ready_o", 1'b1, config_ready_o);
        check_bit("reset weight_ready_o", 1'b0, weight_ready_o);
        check_bit("reset flip_ren_o", 1'b0, flip_ren_o);

        // zero icons keeps the configured spin
        init = $random(seed);
        run_round(init, '0, 1'b1, act_spin, act_energy);
        check_spin("zero_icons spin", init, act_spin);
        check_energy("zero_icons energy", model_energy(init), act_energy);

        fill_icons();
        init = $random(seed);
        n = icon_addr_t'(1 + ($random(seed) & 15));
        run_round(init, n, 1'b1, base_spin, base_energy);
        check_round("greedy", init, n, 1'b1, base_spin, base_energy);

        // same round again with gaps on the weight source
        set_stall(1'b1);
        run_round(init, n, 1'b1, act_spin, act_energy);
        check_round("stall_repeat", init, n, 1'b1, act_spin, act_energy);

        // no comparison means every flip is kept
        fill_icons();
        init = $random(seed);
        n = icon_addr_t'(1 + ($random(seed) & 15));
        run_round(init, n, 1'b0, act_spin, act_energy);
        exp_spin = init;
        for (int i = 0; i < n; i++) begin
            exp_spin = exp_spin ^ icons[i];
        end
        check_spin("no_compare spin", exp_spin, act_spin);
        check_energy("no_compare energy", model_energy(exp_spin), act_energy);

        for (int r = 0; r < MULTI_ROUNDS; r++) begin
            fill_icons();
            init = $random(seed);
            cmp = $random(seed);
            n = icon_addr_t'(($random(seed) & 32'h7fff_ffff) % (MAX_ICONS + 1));
            run_round(init, n, cmp, act_spin, act_energy);
            check_round($sformatf("round_%0d", r), init, n, cmp, act_spin, act_energy);
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: run did not return to idle within %0d cycles", WATCHDOG_CYCLES);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("Simulation failed");
        $finish;
    end

endmodule
